/* common/reg_access_if.sv */
`default_nettype none

interface reg_access_if
  import sim_db_pkg::*;
();

  reg_offset_t offset;    // captured with the strobe
  bus_data_t   wr_data;
  logic        wr_stb;    // one cycle per bus write
  logic        rd_stb;    // one cycle per bus read
  bus_data_t   rd_data;   // held until the next read

  modport port (
    output offset,
    output wr_data,
    output wr_stb,
    output rd_stb,
    input  rd_data
  );

  modport bank (
    input  offset,
    input  wr_data,
    input  wr_stb,
    input  rd_stb,
    output rd_data
  );

endinterface

`default_nettype wire

/* common/sim_db_pkg.sv */
`default_nettype none

package sim_db_pkg;

  // ----------------------------------------------------------------------
  // bus and generator word types
  // ----------------------------------------------------------------------
  typedef logic [11:0] bus_addr_t;     // local bus address
  typedef logic [15:0] bus_data_t;     // one register word
  typedef logic [7:0]  reg_offset_t;   // offset inside the board window
  typedef logic [31:0] freq_word_t;    // frequency / phase accumulator word
  typedef logic [15:0] pulse_count_t;

  // upper address nibble decoded as this board
  localparam logic [3:0] board_window = 4'h8;

  // constant read values
  localparam bus_data_t fpga_version = 16'hb729;
  localparam bus_data_t pattern_aaaa = 16'haaaa;
  localparam bus_data_t pattern_5555 = 16'h5555;

  // ----------------------------------------------------------------------
  // register offsets
  // ----------------------------------------------------------------------
  localparam reg_offset_t off_version  = 8'h00;
  localparam reg_offset_t off_pat_a    = 8'h02;
  localparam reg_offset_t off_pat_5    = 8'h04;

  localparam reg_offset_t off_mode     = 8'h10;  // limited-count bit per pair
  localparam reg_offset_t off_out_ctrl = 8'h12;  // two channel enables per pair
  localparam reg_offset_t off_load     = 8'h14;  // write-only restart strobes

  // pair i low word at base + 4i, high word 2 above it
  localparam reg_offset_t off_freq_base  = 8'h20;
  localparam reg_offset_t off_phase_base = 8'h40;

  // pair i at base + 2i
  localparam reg_offset_t off_pulse_base = 8'h60;

  localparam reg_offset_t off_finished = 8'h70;  // read only

  // room in the map
  localparam int max_pairs = 6;

endpackage

`default_nettype wire

/* common/tacho_cfg_if.sv */
`default_nettype none

interface tacho_cfg_if
  import sim_db_pkg::*;
();

  freq_word_t   freq;
  freq_word_t   phase;       // channel b offset from channel a
  pulse_count_t pulse_num;
  logic         limited;     // stop after pulse_num pulses
  logic [1:0]   enable;      // [0] channel a, [1] channel b
  logic         load;        // one-cycle restart
  logic         finished;

  // register side
  modport bank (
    output freq,
    output phase,
    output pulse_num,
    output limited,
    output enable,
    output load,
    input  finished
  );

  // generator side
  modport pair (
    input  freq,
    input  phase,
    input  pulse_num,
    input  limited,
    input  enable,
    input  load,
    output finished
  );

endinterface

`default_nettype wire

/* filelist.f */
common/sim_db_pkg.sv
common/reg_access_if.sv
common/tacho_cfg_if.sv
logic/local_bus_port.sv
logic/reg_bank.sv
tacho/pulse_limiter.sv
tacho/tacho_pair.sv
logic/sim_db_top.sv
testbench/tb_sim_db.sv

/* logic/local_bus_port.sv */
`default_nettype none

module local_bus_port
  import sim_db_pkg::*;
(
  input  logic       W_clk,
  input  logic       W_reset_n,
  input  bus_addr_t  la,
  input  bus_data_t  ld_in,
  input  logic       lcs_n,
  input  logic       lrd_n,
  input  logic       lwr_n,
  output bus_data_t  ld_out,
  output logic       ld_oe_n,
  reg_access_if.port acc
);

  logic [1:0] cs_sync;   // two sync flops
  logic [2:0] wr_sync;   // two sync flops plus edge history
  logic [2:0] rd_sync;
  logic       in_window;
  logic       wr_fall;
  logic       rd_fall;
  logic       rd_pend;   // bank read data lands this cycle

  // ----------------------------------------------------------------------
  // strobe synchronisers
  // ----------------------------------------------------------------------
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      cs_sync <= 2'b11;
      wr_sync <= 3'b111;
      rd_sync <= 3'b111;
    end
    else
    begin
      cs_sync <= {cs_sync[0], lcs_n};
      wr_sync <= {wr_sync[1:0], lwr_n};
      rd_sync <= {rd_sync[1:0], lrd_n};
    end
  end

  // address is stable for the whole strobe, no sync needed
  assign in_window = !cs_sync[1] && (la[11:8] == board_window);
  assign wr_fall   = in_window && !wr_sync[1] && wr_sync[2];
  assign rd_fall   = in_window && !rd_sync[1] && rd_sync[2];

  // ----------------------------------------------------------------------
  // single-cycle accesses towards the register bank
  // ----------------------------------------------------------------------
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      acc.wr_stb <= 1'b0;
      acc.rd_stb <= 1'b0;
      rd_pend    <= 1'b0;
    end
    else
    begin
      acc.wr_stb <= wr_fall;
      acc.rd_stb <= rd_fall;
      rd_pend    <= acc.rd_stb;
    end
  end

  always_ff @(posedge W_clk)
  begin
    if (wr_fall || rd_fall)
    begin
      acc.offset  <= la[7:0];
      acc.wr_data <= ld_in;
    end
    if (rd_pend)
      ld_out <= acc.rd_data;   // kept until the next read
  end

  assign ld_oe_n = !(in_window && !rd_sync[1]);

  assert property (@(posedge W_clk) disable iff (!W_reset_n)
    !(acc.wr_stb && acc.rd_stb))
    else $error("CHECK FAILED %0t acc.wr_stb/rd_stb expected exclusive, got both high", $time);

endmodule

`default_nettype wire

/* logic/reg_bank.sv */
`default_nettype none

module reg_bank
  import sim_db_pkg::*;
#(
  parameter int num_pairs = 2
)
(
  input  logic       W_clk,
  input  logic       W_reset_n,
  reg_access_if.bank acc,
  tacho_cfg_if.bank  cfg [num_pairs]
);

  logic [num_pairs-1:0]   mode_q;       // limited bit per pair
  logic [2*num_pairs-1:0] out_ctrl_q;   // {ch b, ch a} per pair
  logic [num_pairs-1:0]   load_q;
  logic [num_pairs-1:0]   finished_q;
  logic [num_pairs-1:0]   finished_in;
  freq_word_t             freq_q  [num_pairs];
  freq_word_t             phase_q [num_pairs];
  pulse_count_t           pulse_q [num_pairs];
  bus_data_t              rd_mux;

  if (num_pairs > max_pairs)
  begin : g_map_check
    $error("num_pairs does not fit the register map");
  end

  function automatic reg_offset_t pair_off(input reg_offset_t base, input int idx,
                                           input int stride);
    return base + reg_offset_t'(stride * idx);
  endfunction

  // ----------------------------------------------------------------------
  // write decode
  // ----------------------------------------------------------------------
  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      mode_q     <= '0;
      out_ctrl_q <= '0;
      load_q     <= '0;
      for (int i = 0; i < num_pairs; i++)
      begin
        freq_q[i]  <= '0;
        phase_q[i] <= '0;
        pulse_q[i] <= '0;
      end
    end
    else
    begin
      load_q <= '0;   // self-clearing
      if (acc.wr_stb)
      begin
        case (acc.offset)
          off_mode:     mode_q     <= acc.wr_data[num_pairs-1:0];
          off_out_ctrl: out_ctrl_q <= acc.wr_data[2*num_pairs-1:0];
          off_load:     load_q     <= acc.wr_data[num_pairs-1:0];
          default:      ;
        endcase
        for (int i = 0; i < num_pairs; i++)
        begin
          if (acc.offset == pair_off(off_freq_base, i, 4))
            freq_q[i][15:0] <= acc.wr_data;
          if (acc.offset == pair_off(off_freq_base + 8'h02, i, 4))
            freq_q[i][31:16] <= acc.wr_data;
          if (acc.offset == pair_off(off_phase_base, i, 4))
            phase_q[i][15:0] <= acc.wr_data;
          if (acc.offset == pair_off(off_phase_base + 8'h02, i, 4))
            phase_q[i][31:16] <= acc.wr_data;
          if (acc.offset == pair_off(off_pulse_base, i, 2))
            pulse_q[i] <= acc.wr_data;
        end
      end
    end
  end

  // ----------------------------------------------------------------------
  // read select, unmapped offsets give zero
  // ----------------------------------------------------------------------
  always_comb
  begin
    case (acc.offset)
      off_version:  rd_mux = fpga_version;
      off_pat_a:    rd_mux = pattern_aaaa;
      off_pat_5:    rd_mux = pattern_5555;
      off_mode:     rd_mux = bus_data_t'(mode_q);
      off_out_ctrl: rd_mux = bus_data_t'(out_ctrl_q);
      off_finished: rd_mux = bus_data_t'(finished_q);
      default:      rd_mux = '0;
    endcase
    for (int i = 0; i < num_pairs; i++)
    begin
      if (acc.offset == pair_off(off_freq_base, i, 4))
        rd_mux = freq_q[i][15:0];
      if (acc.offset == pair_off(off_freq_base + 8'h02, i, 4))
        rd_mux = freq_q[i][31:16];
      if (acc.offset == pair_off(off_phase_base, i, 4))
        rd_mux = phase_q[i][15:0];
      if (acc.offset == pair_off(off_phase_base + 8'h02, i, 4))
        rd_mux = phase_q[i][31:16];
      if (acc.offset == pair_off(off_pulse_base, i, 2))
        rd_mux = pulse_q[i];
    end
  end

  always_ff @(posedge W_clk)
  begin
    if (acc.rd_stb)
      acc.rd_data <= rd_mux;
  end

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
      finished_q <= '0;
    else
      finished_q <= finished_in;   // sampled copy of the pair flags
  end

  for (genvar g = 0; g < num_pairs; g++)
  begin : g_pair
    assign cfg[g].freq      = freq_q[g];
    assign cfg[g].phase     = phase_q[g];
    assign cfg[g].pulse_num = pulse_q[g];
    assign cfg[g].limited   = mode_q[g];
    assign cfg[g].enable    = out_ctrl_q[2*g +: 2];
    assign cfg[g].load      = load_q[g];
    assign finished_in[g]   = cfg[g].finished;
  end

  // a load pulse must not stretch into a second restart
  assert property (@(posedge W_clk) disable iff (!W_reset_n)
    (|load_q) |=> !(|load_q))
    else $error("CHECK FAILED %0t load_q expected one-cycle strobe, got %b",
                $time, load_q);

endmodule

`default_nettype wire

/* logic/sim_db_top.sv */
`default_nettype none

module sim_db_top
  import sim_db_pkg::*;
#(
  parameter int num_pairs = 2
)
(
  input  logic                   W_clk,
  input  logic                   W_reset_n,
  input  bus_addr_t              la,
  input  bus_data_t              ld_in,
  input  logic                   lcs_n,
  input  logic                   lrd_n,
  input  logic                   lwr_n,
  output bus_data_t              ld_out,
  output logic                   ld_oe_n,
  output logic [2*num_pairs-1:0] spd_ch   // {ch b, ch a} per pair
);

  reg_access_if acc_bus ();
  tacho_cfg_if  cfg_bus [num_pairs] ();

  // ----------------------------------------------------------------------
  // host side
  // ----------------------------------------------------------------------
  local_bus_port u_bus_port (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (la),
    .ld_in     (ld_in),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .ld_out    (ld_out),
    .ld_oe_n   (ld_oe_n),
    .acc       (acc_bus)
  );

  reg_bank #(
    .num_pairs (num_pairs)
  ) u_reg_bank (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .acc       (acc_bus),
    .cfg       (cfg_bus)
  );

  // ----------------------------------------------------------------------
  // one generator per channel pair
  // ----------------------------------------------------------------------
  for (genvar g = 0; g < num_pairs; g++)
  begin : g_pair
    tacho_pair u_tacho_pair (
      .W_clk     (W_clk),
      .W_reset_n (W_reset_n),
      .cfg       (cfg_bus[g]),
      .spd       (spd_ch[2*g +: 2])
    );
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build with Verilator, run, and decide on the printed result
verilator --binary --timing --assert -Wno-fatal --top-module tb_sim_db \
  -f filelist.f -o sim_db_tb \
  && ./obj_dir/sim_db_tb | tee /dev/stderr | grep -q "^Test OK$" \
  && echo "simulation passed" \
  || { echo "simulation did not pass"; exit 1; }

/* tacho/pulse_limiter.sv */
`default_nettype none

module pulse_limiter
  import sim_db_pkg::*;
(
  input  logic         W_clk,
  input  logic         W_reset_n,
  input  logic         ch_a,
  input  logic         restart,
  input  logic         limited,
  input  pulse_count_t pulse_num,
  output logic         done
);

  pulse_count_t count_q;
  logic         ch_a_q;
  logic         rise;

  assign rise = ch_a && !ch_a_q;

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      count_q <= '0;
      ch_a_q  <= 1'b0;
    end
    else
    begin
      ch_a_q <= ch_a;
      if (restart)
        count_q <= '0;
      else if (rise)
        count_q <= count_q + 1'b1;
    end
  end

  assign done = limited && (count_q == pulse_num);   // one cycle after the edge

  assert property (@(posedge W_clk) disable iff (!W_reset_n)
    done |-> !rise)
    else $error("CHECK FAILED %0t ch_a rise expected none after done, got rise", $time);

endmodule

`default_nettype wire

/* tacho/tacho_pair.sv */
`default_nettype none

module tacho_pair
  import sim_db_pkg::*;
(
  input  logic       W_clk,
  input  logic       W_reset_n,
  tacho_cfg_if.pair  cfg,
  output logic [1:0] spd
);

  freq_word_t acc_q;     // phase accumulator, channel a
  freq_word_t acc_b;     // shifted copy for channel b
  logic       ch_a;
  logic       ch_b;
  logic       done;
  logic       hold;      // keep accumulator at zero
  logic       idle_q;    // accumulator parked last cycle

  assign ch_a  = acc_q[31];
  assign acc_b = acc_q + cfg.phase;
  assign ch_b  = acc_b[31] && !idle_q;   // no phase residue while parked

  // let the last counted pulse finish before parking
  assign hold = !(|cfg.enable) || (done && !ch_a);

  always_ff @(posedge W_clk)
  begin
    if (!W_reset_n)
    begin
      acc_q  <= '0;
      idle_q <= 1'b1;
    end
    else
    begin
      idle_q <= hold;
      if (cfg.load || hold)
        acc_q <= '0;
      else
        acc_q <= acc_q + cfg.freq;
    end
  end

  pulse_limiter u_limiter (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .ch_a      (ch_a),
    .restart   (cfg.load),
    .limited   (cfg.limited),
    .pulse_num (cfg.pulse_num),
    .done      (done)
  );

  assign cfg.finished = done;

  // per-channel output enables
  assign spd[0] = ch_a && cfg.enable[0];
  assign spd[1] = ch_b && cfg.enable[1];

endmodule

`default_nettype wire

/* testbench/tb_sim_db.sv */
`default_nettype none

module tb_sim_db
  import sim_db_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int num_pairs  = 2;
  localparam int bus_cycles = 12;   // 6 low + 6 high per access
  localparam int rise_limit = 40;   // cycles to wait for one edge
  localparam int poll_limit = 20;   // finished register polls

  // test lengths in cycles, summed for the watchdog
  localparam int t1_len    = 8 * bus_cycles;
  localparam int t2_len    = 28 * bus_cycles;
  localparam int t3_len    = 8 * bus_cycles + 4 * rise_limit;
  localparam int t4_len    = 6 * bus_cycles + 4 * rise_limit + 32;
  localparam int t5_len    = (10 + 2 * poll_limit) * bus_cycles + 2 * 80;
  localparam int run_limit = 4 + t1_len + t2_len + t3_len + t4_len + t5_len + 500;

  localparam logic [7:0] off_version  = 8'h00;
  localparam logic [7:0] off_pat_a    = 8'h02;
  localparam logic [7:0] off_pat_5    = 8'h04;
  localparam logic [7:0] off_mode     = 8'h10;
  localparam logic [7:0] off_out_ctrl = 8'h12;
  localparam logic [7:0] off_load     = 8'h14;
  localparam logic [7:0] off_finished = 8'h70;

  logic                   W_clk = 1'b0;
  logic                   W_reset_n;
  bus_addr_t              la;
  bus_data_t              ld_in;
  logic                   lcs_n;
  logic                   lrd_n;
  logic                   lwr_n;
  bus_data_t              ld_out;
  logic                   ld_oe_n;
  logic [2*num_pairs-1:0] spd_ch;

  int          errors       = 0;
  int          failed_tests = 0;
  int          cyc          = 0;
  int          a_rises      = 0;   // rising edges seen on pair 0 channel a
  logic        a_prev       = 1'b0;
  logic [31:0] lfsr         = 32'hdee9_0a8f;
  logic        last_oe_n;
  logic        oe_watch     = 1'b0;   // read outside the window in progress
  logic        pair1_quiet  = 1'b0;
  logic        b_off        = 1'b0;
  logic        a_parked     = 1'b0;

  sim_db_top #(
    .num_pairs (num_pairs)
  ) DUT (
    .W_clk     (W_clk),
    .W_reset_n (W_reset_n),
    .la        (la),
    .ld_in     (ld_in),
    .lcs_n     (lcs_n),
    .lrd_n     (lrd_n),
    .lwr_n     (lwr_n),
    .ld_out    (ld_out),
    .ld_oe_n   (ld_oe_n),
    .spd_ch    (spd_ch)
  );

  always #2 W_clk = ~W_clk;

  always @(posedge W_clk) cyc <= cyc + 1;

  always @(negedge W_clk)
  begin
    a_prev <= spd_ch[0];
    if (spd_ch[0] && !a_prev)
      a_rises <= a_rises + 1;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("CHECK FAILED %0t %s expected %0h got %0h", $time, name, expected, actual);
    errors++;
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual === expected)
    else report_mismatch(name, expected, actual);
  endtask

  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // x^32+x^22+x^2+x+1
  endfunction

  task automatic random_word(output bus_data_t w);
    w = '0;
    for (int i = 0; i < 16; i++)
    begin
      lfsr = lfsr_step(lfsr);
      w    = {w[14:0], lfsr[0]};
    end
  endtask

  function automatic bus_addr_t reg_addr(input logic [7:0] off);
    return {4'h8, off};
  endfunction

  // both bus tasks start and end on a falling edge
  task automatic bus_write(input logic [7:0] off, input bus_data_t data);
    la    = reg_addr(off);
    ld_in = data;
    lcs_n = 1'b0;
    lwr_n = 1'b0;
    repeat (6) @(negedge W_clk);
    lcs_n = 1'b1;
    lwr_n = 1'b1;
    repeat (6) @(negedge W_clk);
  endtask

  task automatic bus_read(input bus_addr_t addr, output bus_data_t data);
    la    = addr;
    lcs_n = 1'b0;
    lrd_n = 1'b0;
    repeat (6) @(negedge W_clk);
    data      = ld_out;   // end of the low phase
    last_oe_n = ld_oe_n;
    lcs_n     = 1'b1;
    lrd_n     = 1'b1;
    repeat (6) @(negedge W_clk);
  endtask

  task automatic wait_rise(input int idx, output int at_cycle);
    logic prev;
    bit   seen;
    prev     = spd_ch[idx];
    seen     = 1'b0;
    at_cycle = 0;
    for (int n = 0; n < rise_limit && !seen; n++)
    begin
      @(negedge W_clk);
      if (spd_ch[idx] && !prev)
      begin
        seen     = 1'b1;
        at_cycle = cyc;
      end
      prev = spd_ch[idx];
    end
    if (!seen)
    begin
      $display("no rising edge on spd_ch[%0d] within %0d cycles", idx, rise_limit);
      errors++;
    end
  endtask

  task automatic wait_finished();
    bus_data_t d;
    bit        seen;
    seen = 1'b0;
    for (int n = 0; n < poll_limit && !seen; n++)
    begin
      bus_read(reg_addr(off_finished), d);
      seen = d[0];
    end
    if (!seen)
    begin
      $display("finished flag of pair 0 never came up");
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int errs_before);
    if (errors == errs_before)
      $display("test %s: no errors", name);
    else
    begin
      $display("test %s: %0d errors", name, errors - errs_before);
      failed_tests++;
    end
  endtask

  // ----------------------------------------------------------------------
  // concurrent checks, armed by the tests
  // ----------------------------------------------------------------------
  assert property (@(posedge W_clk) oe_watch |-> ld_oe_n)
  else report_mismatch("ld_oe_n", 1, $sampled(ld_oe_n));

  assert property (@(posedge W_clk) pair1_quiet |-> spd_ch[3:2] == 2'b00)
  else report_mismatch("spd_ch[3:2]", 0, $sampled(spd_ch[3:2]));

  assert property (@(posedge W_clk) b_off |-> !spd_ch[1])
  else report_mismatch("spd_ch[1]", 0, $sampled(spd_ch[1]));

  assert property (@(posedge W_clk) a_parked |-> !spd_ch[0])
  else report_mismatch("spd_ch[0]", 0, $sampled(spd_ch[0]));

  initial
  begin
    repeat (run_limit) @(posedge W_clk);
    $display("run did not finish within %0d cycles", run_limit);
    $display("Test FAILED");
    $finish;
  end

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    bus_data_t  d;
    bus_data_t  words [5*num_pairs];
    logic [7:0] offs  [5*num_pairs];
    int         mark;
    int         t0;
    int         t1;

    W_reset_n = 1'b0;
    la        = '0;
    ld_in     = '0;
    lcs_n     = 1'b1;
    lrd_n     = 1'b1;
    lwr_n     = 1'b1;
    repeat (4) @(negedge W_clk);
    W_reset_n = 1'b1;

    // 1: constant registers and the window
    mark = errors;
    check_value("ld_oe_n", 1, ld_oe_n);
    check_value("spd_ch", 0, spd_ch);
    bus_read(reg_addr(off_version), d);
    check_value("ld_out version", 16'hb729, d);
    check_value("ld_oe_n", 0, last_oe_n);
    bus_read(reg_addr(off_pat_a), d);
    check_value("ld_out pattern a", 16'haaaa, d);
    bus_read(reg_addr(off_pat_5), d);
    check_value("ld_out pattern 5", 16'h5555, d);
    bus_read(reg_addr(8'h30), d);   // unmapped
    check_value("ld_out unmapped", 0, d);
    bus_read(reg_addr(off_mode), d);
    check_value("ld_out mode", 0, d);
    bus_read(reg_addr(off_finished), d);
    check_value("ld_out finished", 0, d);
    oe_watch = 1'b1;
    bus_read(12'h302, d);
    oe_watch = 1'b0;
    check_value("ld_out held", 0, d);
    report_test("identification", mark);

    // 2: read back of random words
    mark = errors;
    for (int i = 0; i < num_pairs; i++)
    begin
      offs[5*i]     = 8'h20 + 8'(4*i);
      offs[5*i + 1] = 8'h22 + 8'(4*i);
      offs[5*i + 2] = 8'h40 + 8'(4*i);
      offs[5*i + 3] = 8'h42 + 8'(4*i);
      offs[5*i + 4] = 8'h60 + 8'(2*i);
    end
    for (int i = 0; i < 5*num_pairs; i++)
    begin
      random_word(words[i]);
      bus_write(offs[i], words[i]);
    end
    for (int i = 0; i < 5*num_pairs; i++)
    begin
      bus_read(reg_addr(offs[i]), d);
      check_value($sformatf("ld_out at %0h", offs[i]), words[i], d);
    end
    random_word(d);
    bus_write(off_out_ctrl, d);
    bus_read(reg_addr(off_out_ctrl), t0[15:0]);
    check_value("ld_out out_ctrl", d & 16'h000f, t0[15:0]);
    random_word(d);
    bus_write(off_mode, d);
    bus_read(reg_addr(off_mode), t0[15:0]);
    check_value("ld_out mode", d & 16'h0003, t0[15:0]);
    bus_write(off_out_ctrl, 16'h0000);
    bus_write(off_mode, 16'h0000);
    report_test("register read back", mark);

    // 3: period 16 on pair 0, pair 1 disabled
    mark = errors;
    pair1_quiet = 1'b1;
    bus_write(8'h20, 16'h0000);
    bus_write(8'h22, 16'h1000);   // freq 2^28
    bus_write(off_out_ctrl, 16'h0003);
    bus_write(off_load, 16'h0001);
    wait_rise(0, t0);
    for (int k = 0; k < 3; k++)
    begin
      wait_rise(0, t1);
      check_value("spd_ch[0] period", 16, t1 - t0);
      t0 = t1;
    end
    report_test("channel period", mark);

    // 4: quarter turn phase, then channel b off
    mark = errors;
    bus_write(8'h40, 16'h0000);
    bus_write(8'h42, 16'h4000);   // phase 2^30
    bus_write(off_load, 16'h0001);
    for (int k = 0; k < 2; k++)
    begin
      wait_rise(1, t0);
      wait_rise(0, t1);
      check_value("spd_ch[1] to spd_ch[0] rise gap", 4, t1 - t0);
    end
    bus_write(off_out_ctrl, 16'h0001);
    b_off = 1'b1;
    t0    = a_rises;
    repeat (32) @(negedge W_clk);
    check_value("spd_ch[0] rises in 32 cycles", 2, a_rises - t0);
    report_test("channel phase", mark);

    // 5: limited run of 5 pulses
    mark = errors;
    bus_write(off_out_ctrl, 16'h0000);   // park pair 0
    bus_write(8'h60, 16'h0005);
    bus_write(off_mode, 16'h0001);
    bus_write(off_load, 16'h0001);
    t0 = a_rises;
    bus_write(off_out_ctrl, 16'h0001);
    wait_finished();
    bus_read(reg_addr(off_finished), d);
    check_value("ld_out finished", 16'h0001, d);
    repeat (16) @(negedge W_clk);        // last high half of channel a
    a_parked = 1'b1;
    repeat (64) @(negedge W_clk);
    check_value("spd_ch[0] rise count", 5, a_rises - t0);
    a_parked = 1'b0;
    t0 = a_rises;
    bus_write(off_load, 16'h0001);
    bus_read(reg_addr(off_finished), d);
    check_value("ld_out finished after load", 0, d);
    wait_finished();
    repeat (16) @(negedge W_clk);
    check_value("spd_ch[0] rise count after load", 5, a_rises - t0);
    report_test("pulse limit", mark);

    $display("tests run 5, tests with errors %0d, errors %0d", failed_tests, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire
